// ==== source/periph_pkg.sv ====
//**************************************************************************
// Bus widths, APB memory map and register indices for the peripherals
// Only paddr 15:13 (slot) and 3:2 (register) are decoded
//**************************************************************************
package periph_pkg;

   localparam int APB_ADDR_WIDTH   = 20;
   localparam int APB_DATA_WIDTH   = 32;
   localparam int GPIO_PINS        = 32;
   localparam int GPIO_SYNC_STAGES = 2;

   // Address fields
   localparam int SLOT_LSB = 13;
   localparam int SLOT_MSB = 15;
   localparam int REG_LSB  = 2;
   localparam int REG_MSB  = 3;

   typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
   typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
   typedef logic [GPIO_PINS-1:0]      gpio_word_t;

   //***********************************************************************
   // APB request and response
   //***********************************************************************
   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   // Answer for an unmapped slot
   localparam apb_rsp_t APB_ERR_RSP = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};

   //***********************************************************************
   // Memory map and register indices
   //***********************************************************************
   typedef enum logic [SLOT_MSB-SLOT_LSB:0] {
      SLOT_TIMER = 3'd1,   // 0x2000
      SLOT_PWM   = 3'd2,   // 0x4000
      SLOT_GPIO  = 3'd4    // 0x8000
   } periph_slot_e;

   typedef enum logic [REG_MSB-REG_LSB:0] {
      TMR_CTRL    = 2'd0,
      TMR_COMPARE = 2'd1,
      TMR_COUNT   = 2'd2
   } timer_reg_e;

   typedef enum logic [REG_MSB-REG_LSB:0] {
      GPIO_DIR = 2'd0,
      GPIO_OUT = 2'd1,
      GPIO_IN  = 2'd2      // Read only
   } gpio_reg_e;

   typedef enum logic [REG_MSB-REG_LSB:0] {
      PWM_PERIOD = 2'd0,
      PWM_DUTY   = 2'd1,
      PWM_CTRL   = 2'd2
   } pwm_reg_e;

   // Timer control bits as laid out in TMR_CTRL
   typedef struct packed {
      logic irq_en;        // Bit 1
      logic enable;        // Bit 0
   } timer_ctrl_t;

endpackage

// ==== source/apb_decoder.sv ====
//**************************************************************************
// APB slot decoder on paddr 15:13 with response mux
// Unmapped slots get an error response in the same access cycle
//**************************************************************************
module apb_decoder (
   input  logic                 clk,
   input  logic                 reset_i,
   input  periph_pkg::apb_req_t req_i,
   output periph_pkg::apb_rsp_t rsp_o,
   output periph_pkg::apb_req_t timer_req_o,
   output periph_pkg::apb_req_t pwm_req_o,
   output periph_pkg::apb_req_t gpio_req_o,
   input  periph_pkg::apb_rsp_t timer_rsp_i,
   input  periph_pkg::apb_rsp_t pwm_rsp_i,
   input  periph_pkg::apb_rsp_t gpio_rsp_i
);
   import periph_pkg::*;

   periph_slot_e slot;

   assign slot = periph_slot_e'(req_i.paddr[SLOT_MSB:SLOT_LSB]);

   //***********************************************************************
   // Select fan-out and response return
   //***********************************************************************
   always_comb begin
      // Every peripheral sees the bus, only one sees psel
      timer_req_o      = req_i;
      pwm_req_o        = req_i;
      gpio_req_o       = req_i;
      timer_req_o.psel = 1'b0;
      pwm_req_o.psel   = 1'b0;
      gpio_req_o.psel  = 1'b0;
      rsp_o            = APB_ERR_RSP;

      case (slot)
         SLOT_TIMER: begin
            timer_req_o.psel = req_i.psel;
            rsp_o            = timer_rsp_i;
         end
         SLOT_PWM: begin
            pwm_req_o.psel = req_i.psel;
            rsp_o          = pwm_rsp_i;
         end
         SLOT_GPIO: begin
            gpio_req_o.psel = req_i.psel;
            rsp_o           = gpio_rsp_i;
         end
         default: begin
            rsp_o = APB_ERR_RSP;     // Nothing selected
         end
      endcase
   end

   // At most one peripheral is ever selected
   a_one_psel: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0({timer_req_o.psel, pwm_req_o.psel, gpio_req_o.psel}));

endmodule

// ==== source/apb_timer.sv ====
//**************************************************************************
// Compare timer. The count wraps to 0 on the edge after it equals compare
// A compare below the current count lets the count run through 2^32 first
//**************************************************************************
module apb_timer (
   input  logic                 clk,
   input  logic                 reset_i,
   input  periph_pkg::apb_req_t req_i,
   output periph_pkg::apb_rsp_t rsp_o,
   output logic                 timer_irq_o
);
   import periph_pkg::*;

   localparam int CTRL_BITS = $bits(timer_ctrl_t);

   timer_ctrl_t ctrl_q;
   timer_ctrl_t ctrl_d;
   apb_data_t   compare_q;
   apb_data_t   count_q;
   logic        irq_q;
   timer_reg_e  reg_sel;
   logic        wr_en;
   logic        hit;

   assign reg_sel = timer_reg_e'(req_i.paddr[REG_MSB:REG_LSB]);
   assign wr_en   = req_i.psel & req_i.penable & req_i.pwrite;
   assign hit     = ctrl_q.enable & (count_q == compare_q);

   // Control value after this edge
   always_comb begin
      ctrl_d = ctrl_q;
      if (wr_en && reg_sel == TMR_CTRL) begin
         ctrl_d = timer_ctrl_t'(req_i.pwdata[CTRL_BITS-1:0]);
      end
   end

   //***********************************************************************
   // Registers and counter
   //***********************************************************************
   always_ff @(posedge clk) begin
      if (reset_i) begin
         ctrl_q    <= '0;
         compare_q <= '0;
         count_q   <= '0;
         irq_q     <= 1'b0;
      end else begin
         ctrl_q <= ctrl_d;
         irq_q  <= hit & ctrl_d.irq_en;     // One pulse per wrap
         if (wr_en && reg_sel == TMR_COMPARE) begin
            compare_q <= req_i.pwdata;
         end
         if (wr_en && reg_sel == TMR_COUNT) begin
            count_q <= req_i.pwdata;        // Bus write wins
         end else if (hit) begin
            count_q <= '0;
         end else if (ctrl_q.enable) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   // Read mux, zero wait states
   always_comb begin
      rsp_o.pready  = 1'b1;
      rsp_o.pslverr = 1'b0;
      case (reg_sel)
         TMR_CTRL:    rsp_o.prdata = {{(APB_DATA_WIDTH-CTRL_BITS){1'b0}}, ctrl_q};
         TMR_COMPARE: rsp_o.prdata = compare_q;
         TMR_COUNT:   rsp_o.prdata = count_q;
         default:     rsp_o.prdata = '0;
      endcase
   end

   assign timer_irq_o = irq_q;

   // A pulse is only seen while the interrupt stays enabled
   a_irq_enabled: assert property (@(posedge clk) disable iff (reset_i)
      timer_irq_o |-> ctrl_q.irq_en);

endmodule

// ==== source/apb_gpio.sv ====
//**************************************************************************
// 32-pin GPIO with direction and output registers
// GPIO_IN shows the pins two clocks late and ignores writes
//**************************************************************************
module apb_gpio (
   input  logic                   clk,
   input  logic                   reset_i,
   input  periph_pkg::apb_req_t   req_i,
   output periph_pkg::apb_rsp_t   rsp_o,
   input  periph_pkg::gpio_word_t gpio_i,
   output periph_pkg::gpio_word_t gpio_o,
   output periph_pkg::gpio_word_t gpio_oe_o
);
   import periph_pkg::*;

   gpio_word_t                        dir_q;
   gpio_word_t                        out_q;
   gpio_word_t [GPIO_SYNC_STAGES-1:0] sync_q;
   gpio_word_t                        pins_in;
   gpio_reg_e                         reg_sel;
   logic                              wr_en;

   assign reg_sel = gpio_reg_e'(req_i.paddr[REG_MSB:REG_LSB]);
   assign wr_en   = req_i.psel & req_i.penable & req_i.pwrite;
   assign pins_in = sync_q[GPIO_SYNC_STAGES-1];   // Last stage

   //***********************************************************************
   // Input synchronizer
   //***********************************************************************
   always_ff @(posedge clk) begin
      if (reset_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[GPIO_SYNC_STAGES-2:0], gpio_i};
      end
   end

   // Direction and output registers
   always_ff @(posedge clk) begin
      if (reset_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (wr_en) begin
         case (reg_sel)
            GPIO_DIR: dir_q <= req_i.pwdata;
            GPIO_OUT: out_q <= req_i.pwdata;
            default: begin
               // GPIO_IN and the spare index hold nothing
               dir_q <= dir_q;
            end
         endcase
      end
   end

   // Read mux
   always_comb begin
      rsp_o.pready  = 1'b1;
      rsp_o.pslverr = 1'b0;
      case (reg_sel)
         GPIO_DIR: rsp_o.prdata = dir_q;
         GPIO_OUT: rsp_o.prdata = out_q;
         GPIO_IN:  rsp_o.prdata = pins_in;
         default:  rsp_o.prdata = '0;
      endcase
   end

   assign gpio_o    = out_q;
   assign gpio_oe_o = dir_q;    // 1 drives the pin

endmodule

// ==== source/apb_pwm.sv ====
//**************************************************************************
// Single-pin PWM. The counter runs 0 to period-1 and a zero period holds it
// pwm_o is high while the count is below duty and is one clock behind it
//**************************************************************************
module apb_pwm (
   input  logic                 clk,
   input  logic                 reset_i,
   input  periph_pkg::apb_req_t req_i,
   output periph_pkg::apb_rsp_t rsp_o,
   output logic                 pwm_o,
   output logic                 pwm_oe_o
);
   import periph_pkg::*;

   apb_data_t period_q;
   apb_data_t duty_q;
   apb_data_t cnt_q;
   logic      en_q;
   logic      en_d;
   logic      pwm_q;
   pwm_reg_e  reg_sel;
   logic      wr_en;
   logic      cnt_wrap;

   assign reg_sel  = pwm_reg_e'(req_i.paddr[REG_MSB:REG_LSB]);
   assign wr_en    = req_i.psel & req_i.penable & req_i.pwrite;
   assign cnt_wrap = (cnt_q >= period_q - 1'b1);     // Also catches a shrunk period
   assign en_d     = (wr_en && reg_sel == PWM_CTRL) ? req_i.pwdata[0] : en_q;

   //***********************************************************************
   // Registers, period counter and output flop
   //***********************************************************************
   always_ff @(posedge clk) begin
      if (reset_i) begin
         period_q <= '0;
         duty_q   <= '0;
         en_q     <= 1'b0;
         cnt_q    <= '0;
         pwm_q    <= 1'b0;
      end else begin
         en_q <= en_d;
         if (wr_en && reg_sel == PWM_PERIOD) begin
            period_q <= req_i.pwdata;
         end
         if (wr_en && reg_sel == PWM_DUTY) begin
            duty_q <= req_i.pwdata;
         end

         if (!en_q || period_q == '0 || cnt_wrap) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end

         // Drops on the edge that disables
         pwm_q <= en_q & en_d & (cnt_q < duty_q);
      end
   end

   // Read mux
   always_comb begin
      rsp_o.pready  = 1'b1;
      rsp_o.pslverr = 1'b0;
      case (reg_sel)
         PWM_PERIOD: rsp_o.prdata = period_q;
         PWM_DUTY:   rsp_o.prdata = duty_q;
         PWM_CTRL:   rsp_o.prdata = {{(APB_DATA_WIDTH-1){1'b0}}, en_q};
         default:    rsp_o.prdata = '0;
      endcase
   end

   assign pwm_o    = pwm_q;
   assign pwm_oe_o = en_q;

   a_pwm_off: assert property (@(posedge clk) disable iff (reset_i)
      !en_q |-> !pwm_o);

endmodule

// ==== source/periph_subsystem.sv ====
//**************************************************************************
// Peripheral subsystem behind one APB slave port
// Every transfer takes setup plus one access cycle
//**************************************************************************
module periph_subsystem (
   input  logic                   clk,
   input  logic                   reset_i,
   input  periph_pkg::apb_req_t   apb_req_i,
   output periph_pkg::apb_rsp_t   apb_rsp_o,
   input  periph_pkg::gpio_word_t gpio_i,
   output periph_pkg::gpio_word_t gpio_o,
   output periph_pkg::gpio_word_t gpio_oe_o,
   output logic                   timer_irq_o,
   output logic                   pwm_o,
   output logic                   pwm_oe_o
);
   import periph_pkg::*;

   apb_req_t timer_req;
   apb_req_t pwm_req;
   apb_req_t gpio_req;
   apb_rsp_t timer_rsp;
   apb_rsp_t pwm_rsp;
   apb_rsp_t gpio_rsp;

   //***********************************************************************
   // Address decode
   //***********************************************************************
   apb_decoder apb_decoder_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .req_i       (apb_req_i),
      .rsp_o       (apb_rsp_o),
      .timer_req_o (timer_req),
      .pwm_req_o   (pwm_req),
      .gpio_req_o  (gpio_req),
      .timer_rsp_i (timer_rsp),
      .pwm_rsp_i   (pwm_rsp),
      .gpio_rsp_i  (gpio_rsp)
   );

   //***********************************************************************
   // Peripherals
   //***********************************************************************
   apb_timer apb_timer_i (        // 0x2000
      .clk         (clk),
      .reset_i     (reset_i),
      .req_i       (timer_req),
      .rsp_o       (timer_rsp),
      .timer_irq_o (timer_irq_o)
   );

   apb_pwm apb_pwm_i (            // 0x4000
      .clk      (clk),
      .reset_i  (reset_i),
      .req_i    (pwm_req),
      .rsp_o    (pwm_rsp),
      .pwm_o    (pwm_o),
      .pwm_oe_o (pwm_oe_o)
   );

   apb_gpio apb_gpio_i (          // 0x8000
      .clk       (clk),
      .reset_i   (reset_i),
      .req_i     (gpio_req),
      .rsp_o     (gpio_rsp),
      .gpio_i    (gpio_i),
      .gpio_o    (gpio_o),
      .gpio_oe_o (gpio_oe_o)
   );

endmodule

// ==== sim/tb_clock_gen.sv ====
//**************************************************************************
// Free-running testbench clock, period 100, starts low
//**************************************************************************
module tb_clock_gen (
   output logic clk_o
);

   localparam int HALF_PERIOD = 50;

   initial begin
      clk_o = 1'b0;
   end

   always begin
      #HALF_PERIOD clk_o = ~clk_o;
   end

endmodule

// ==== sim/periph_subsystem_tb.sv ====
//**************************************************************************
// Directed tests for the APB peripheral subsystem
// Inputs change on the rising edge, outputs are sampled on the falling edge
//**************************************************************************
module periph_subsystem_tb;
   import periph_pkg::*;

   localparam int          RESET_CYCLES       = 10;
   localparam int          NUM_TESTS          = 5;
   localparam int          TEST_BUDGET_CYCLES = 200;  // Worst test is about 160
   localparam int          MARGIN_CYCLES      = 200;
   localparam int          WATCHDOG_CYCLES    =
      RESET_CYCLES + NUM_TESTS * TEST_BUDGET_CYCLES + MARGIN_CYCLES;
   localparam logic [31:0] LFSR_SEED          = 32'd30;
   localparam logic [31:0] LFSR_TAPS          = 32'h8020_0003;

   logic       clk;
   logic       reset_i;
   apb_req_t   apb_req;
   apb_rsp_t   apb_rsp;
   gpio_word_t gpio_in;
   gpio_word_t gpio_out;
   gpio_word_t gpio_oe;
   logic       timer_irq;
   logic       pwm_out;
   logic       pwm_oe;

   logic [31:0] lfsr_state;
   int          test_errors;
   int          tests_passed;
   int          tests_failed;

   // Values left in the registers by the readback test
   apb_data_t   tmr_compare_val;
   apb_data_t   pwm_period_val;
   apb_data_t   pwm_duty_val;
   apb_data_t   gpio_dir_val;
   apb_data_t   gpio_out_val;

   tb_clock_gen tb_clock_gen_i (.clk_o(clk));

   periph_subsystem periph_subsystem_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .apb_req_i   (apb_req),
      .apb_rsp_o   (apb_rsp),
      .gpio_i      (gpio_in),
      .gpio_o      (gpio_out),
      .gpio_oe_o   (gpio_oe),
      .timer_irq_o (timer_irq),
      .pwm_o       (pwm_out),
      .pwm_oe_o    (pwm_oe)
   );

   //***********************************************************************
   // Random numbers and addresses
   //***********************************************************************
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   function automatic apb_data_t rand_bits(input int n);
      apb_data_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};   // One step per bit
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   function automatic apb_addr_t reg_addr(input logic [2:0] slot, input logic [1:0] idx);
      apb_addr_t a;
      a                    = '0;
      a[SLOT_MSB:SLOT_LSB] = slot;
      a[REG_MSB:REG_LSB]   = idx;
      return a;
   endfunction

   //***********************************************************************
   // Compare tasks and test bookkeeping
   //***********************************************************************
   task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_err(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s pslverr %b, expected %b", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_gpio(input gpio_word_t got, input gpio_word_t exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   //***********************************************************************
   // APB driver, setup then one access cycle
   //***********************************************************************
   task automatic apb_transfer(input logic write, input apb_addr_t addr,
                               input apb_data_t wdata, output apb_data_t rdata,
                               output logic slverr);
      @(posedge clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= write;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);                         // Access cycle, response settled
      if (apb_rsp.pready !== 1'b1) begin
         $display("[ERROR] %0t: pready %b in the access cycle at address %h, expected 1",
                  $time, apb_rsp.pready, addr);
         test_errors++;
      end
      rdata  = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      @(posedge clk);                         // Transfer ends on this edge
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic slverr);
      apb_data_t unused_rdata;
      apb_transfer(1'b1, addr, data, unused_rdata, slverr);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic slverr);
      apb_transfer(1'b0, addr, '0, data, slverr);
   endtask

   task automatic write_and_verify(input apb_addr_t addr, input apb_data_t value,
                                   input string name);
      apb_data_t rdata;
      logic      err;
      apb_write(addr, value, err);
      check_err(err, 1'b0, {name, " write"});
      apb_read(addr, rdata, err);
      check_err(err, 1'b0, {name, " read"});
      check_data(rdata, value, name);
   endtask

   task automatic verify_reg(input apb_addr_t addr, input apb_data_t value, input string name);
      apb_data_t rdata;
      logic      err;
      apb_read(addr, rdata, err);
      check_err(err, 1'b0, name);
      check_data(rdata, value, name);
   endtask

   //***********************************************************************
   // Directed tests
   //***********************************************************************
   task automatic test_readback();
      tmr_compare_val = rand_bits(32);
      pwm_period_val  = rand_bits(32);
      pwm_duty_val    = rand_bits(32);
      gpio_dir_val    = rand_bits(32);
      gpio_out_val    = rand_bits(32);
      write_and_verify(reg_addr(SLOT_TIMER, TMR_COMPARE), tmr_compare_val, "TMR_COMPARE");
      write_and_verify(reg_addr(SLOT_PWM, PWM_PERIOD), pwm_period_val, "PWM_PERIOD");
      write_and_verify(reg_addr(SLOT_PWM, PWM_DUTY), pwm_duty_val, "PWM_DUTY");
      write_and_verify(reg_addr(SLOT_GPIO, GPIO_DIR), gpio_dir_val, "GPIO_DIR");
      write_and_verify(reg_addr(SLOT_GPIO, GPIO_OUT), gpio_out_val, "GPIO_OUT");
      finish_test("register readback");
   endtask

   task automatic test_unmapped();
      apb_data_t tmp;
      apb_data_t rdata;
      apb_addr_t addr;
      logic      err;
      for (int s = 0; s < 8; s++) begin
         if (s != 1 && s != 2 && s != 4) begin
            tmp  = rand_bits(2);
            addr = reg_addr(s[2:0], tmp[1:0]);
            apb_write(addr, rand_bits(32), err);
            check_err(err, 1'b1, "unmapped write");
            apb_read(addr, rdata, err);
            check_err(err, 1'b1, "unmapped read");
            check_data(rdata, '0, "unmapped read");
         end
      end
      // Nothing may have leaked into a real peripheral
      verify_reg(reg_addr(SLOT_TIMER, TMR_COMPARE), tmr_compare_val, "TMR_COMPARE");
      verify_reg(reg_addr(SLOT_PWM, PWM_PERIOD), pwm_period_val, "PWM_PERIOD");
      verify_reg(reg_addr(SLOT_PWM, PWM_DUTY), pwm_duty_val, "PWM_DUTY");
      verify_reg(reg_addr(SLOT_GPIO, GPIO_DIR), gpio_dir_val, "GPIO_DIR");
      verify_reg(reg_addr(SLOT_GPIO, GPIO_OUT), gpio_out_val, "GPIO_OUT");
      finish_test("unmapped slots");
   endtask

   task automatic test_gpio();
      gpio_word_t pins;
      apb_data_t  rdata;
      logic       err;
      gpio_dir_val = rand_bits(32);
      gpio_out_val = rand_bits(32);
      apb_write(reg_addr(SLOT_GPIO, GPIO_DIR), gpio_dir_val, err);
      apb_write(reg_addr(SLOT_GPIO, GPIO_OUT), gpio_out_val, err);
      @(negedge clk);
      check_gpio(gpio_oe, gpio_dir_val, "gpio_oe_o");
      check_gpio(gpio_out, gpio_out_val, "gpio_o");
      repeat (2) begin
         pins = rand_bits(32);
         @(posedge clk);
         gpio_in <= pins;
         repeat (3) @(posedge clk);           // Past the two sync stages
         apb_read(reg_addr(SLOT_GPIO, GPIO_IN), rdata, err);
         check_err(err, 1'b0, "GPIO_IN read");
         check_gpio(rdata, pins, "GPIO_IN");
      end
      finish_test("gpio");
   endtask

   task automatic test_timer();
      apb_data_t cmp;
      logic      err;
      int        cycle;
      int        last_pulse;
      int        pulses;
      int        limit;
      int        quiet_highs;
      cmp = 3 + rand_bits(3);
      apb_write(reg_addr(SLOT_TIMER, TMR_CTRL), '0, err);
      apb_write(reg_addr(SLOT_TIMER, TMR_COUNT), '0, err);
      apb_write(reg_addr(SLOT_TIMER, TMR_COMPARE), cmp, err);
      apb_write(reg_addr(SLOT_TIMER, TMR_CTRL), 32'h3, err);   // Enable and irq enable
      cycle      = 0;
      last_pulse = 0;
      pulses     = 0;
      limit      = 4 * (cmp + 1) + 8;
      while (pulses < 4 && cycle < limit) begin
         @(negedge clk);
         cycle++;
         if (timer_irq) begin
            if (pulses > 0) begin
               check_data(cycle - last_pulse, cmp + 1, "timer pulse spacing");
            end
            last_pulse = cycle;
            pulses++;
         end
      end
      if (pulses < 4) begin
         $display("%0t: timer interrupt stopped arriving, %0d of 4 pulses seen", $time, pulses);
         test_errors++;
      end
      apb_write(reg_addr(SLOT_TIMER, TMR_CTRL), 32'h1, err);   // Count on, irq off
      quiet_highs = 0;
      repeat (3 * (cmp + 1)) begin
         @(negedge clk);
         if (timer_irq) begin
            quiet_highs++;
         end
      end
      check_data(quiet_highs, '0, "timer pulses with irq enable clear");
      apb_write(reg_addr(SLOT_TIMER, TMR_CTRL), '0, err);
      finish_test("timer");
   endtask

   task automatic test_pwm();
      apb_data_t period;
      apb_data_t duty;
      logic      err;
      int        highs;
      int        oe_low;
      period = 4 + rand_bits(4);
      duty   = 1 + rand_bits(8) % (period - 1);   // At least one high cycle
      apb_write(reg_addr(SLOT_PWM, PWM_PERIOD), period, err);
      apb_write(reg_addr(SLOT_PWM, PWM_DUTY), duty, err);
      apb_write(reg_addr(SLOT_PWM, PWM_CTRL), 32'h1, err);
      repeat (2 * period) @(negedge clk);    // Settle into the period
      repeat (3) begin
         highs  = 0;
         oe_low = 0;
         repeat (period) begin
            @(negedge clk);
            if (pwm_out) highs++;
            if (!pwm_oe) oe_low++;
         end
         check_data(highs, duty, "pwm high cycles per period");
         check_data(oe_low, '0, "pwm_oe_o low cycles while enabled");
      end
      apb_write(reg_addr(SLOT_PWM, PWM_CTRL), '0, err);
      highs = 0;
      repeat (2 * period) begin
         @(negedge clk);
         if (pwm_out || pwm_oe) highs++;
      end
      check_data(highs, '0, "pwm cycles active after disable");
      finish_test("pwm");
   endtask

   //***********************************************************************
   // Main sequence and watchdog
   //***********************************************************************
   initial begin
      reset_i      <= 1'b1;
      apb_req      <= '0;
      gpio_in      <= '0;
      lfsr_state    = LFSR_SEED;
      test_errors   = 0;
      tests_passed  = 0;
      tests_failed  = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_i <= 1'b0;

      test_readback();
      test_unmapped();
      test_gpio();
      test_timer();
      test_pwm();

      $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

// ==== src.f ====
source/periph_pkg.sv
source/apb_decoder.sv
source/apb_timer.sv
source/apb_gpio.sv
source/apb_pwm.sv
source/periph_subsystem.sv
sim/tb_clock_gen.sv
sim/periph_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module periph_subsystem_tb \
      -f src.f -o periph_sim \
   && ./obj_dir/periph_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
